/* source/l2_pkg.sv */
package l2_pkg;

    // byte address from the first-level cache
    localparam int ADDR_BITS = 16;

    // 16 bytes per line
    localparam int OFFSET_BITS = 4;

    localparam int LINE_BITS = 128;

    // 16-bit byte address
    typedef logic [ADDR_BITS-1:0] l2_addr;

    // one full cache line
    typedef logic [LINE_BITS-1:0] l2_line;

    // hit and miss statistics
    typedef logic [15:0] l2_count;

endpackage : l2_pkg

/* source/l2_cache_way.sv */
`timescale 1ns/1ps

module l2_cache_way import l2_pkg::*; #(
    parameter int INDEX_BITS = 3
) (
    input  logic                                      clk,
    input  logic                                      arst_n,

    input  logic [INDEX_BITS-1:0]                     index,
    input  logic                                      load,
    input  logic [ADDR_BITS-INDEX_BITS-OFFSET_BITS-1:0] tag_in,
    input  l2_line                                    line_in,
    input  logic                                      dirty_in,

    output logic [ADDR_BITS-INDEX_BITS-OFFSET_BITS-1:0] tag_out,
    output logic                                      valid_out,
    output logic                                      dirty_out,
    output l2_line                                    line_out
);

    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int SETS     = 1 << INDEX_BITS;

    logic [TAG_BITS-1:0] tag_mem [SETS];
    l2_line              line_mem [SETS];
    logic [SETS-1:0]     valid;
    logic [SETS-1:0]     dirty;

    // status bits per set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (load) begin
            valid[index] <= 1'b1;
            dirty[index] <= dirty_in;
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (load) begin
            tag_mem[index]  <= tag_in;
            line_mem[index] <= line_in;
        end
    end

    // asynchronous read of the addressed set
    assign tag_out   = tag_mem[index];
    assign line_out  = line_mem[index];
    assign valid_out = valid[index];
    assign dirty_out = dirty[index];

endmodule : l2_cache_way

/* source/l2_cache_datapath.sv */
`timescale 1ns/1ps

module l2_cache_datapath import l2_pkg::*; #(
    parameter int INDEX_BITS = 3
) (
    input  logic   clk,
    input  logic   arst_n,

    // cpu request
    input  l2_addr mem_address,
    input  l2_line mem_wdata,
    output l2_line mem_rdata,

    // main memory
    input  l2_line pmem_rdata,
    output l2_line pmem_wdata,
    output l2_addr pmem_address,

    // control strobes and selects
    input  logic   load_way0,
    input  logic   load_way1,
    input  logic   load_lru,
    input  logic   cpu_line_sel,
    input  logic   dirty_set,
    input  logic   wb_way_sel,

    // status to control
    output logic   hit,
    output logic   hit_way,
    output logic   lru_way,
    output logic   victim_dirty
);

    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int SETS     = 1 << INDEX_BITS;

    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag0;
    logic [TAG_BITS-1:0]   tag1;
    logic [TAG_BITS-1:0]   victim_tag;
    logic                  valid0;
    logic                  valid1;
    logic                  dirty0;
    logic                  dirty1;
    logic                  hit0;
    logic                  hit1;
    l2_line                line0;
    l2_line                line1;
    l2_line                fill_line;
    l2_line                line_in;
    logic [SETS-1:0]       lru;

    assign req_tag = mem_address[ADDR_BITS-1 -: TAG_BITS];
    assign index   = mem_address[OFFSET_BITS +: INDEX_BITS];

    // memory data is only valid with pmem_resp, keep it for the fill cycle
    always_ff @(posedge clk) begin
        fill_line <= pmem_rdata;
    end

    assign line_in = cpu_line_sel ? mem_wdata : fill_line;

    l2_cache_way #(.INDEX_BITS(INDEX_BITS)) way0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (index),
        .load      (load_way0),
        .tag_in    (req_tag),
        .line_in   (line_in),
        .dirty_in  (dirty_set),
        .tag_out   (tag0),
        .valid_out (valid0),
        .dirty_out (dirty0),
        .line_out  (line0)
    );

    l2_cache_way #(.INDEX_BITS(INDEX_BITS)) way1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (index),
        .load      (load_way1),
        .tag_in    (req_tag),
        .line_in   (line_in),
        .dirty_in  (dirty_set),
        .tag_out   (tag1),
        .valid_out (valid1),
        .dirty_out (dirty1),
        .line_out  (line1)
    );

    assign hit0      = valid0 && (tag0 == req_tag);
    assign hit1      = valid1 && (tag1 == req_tag);
    assign hit       = hit0 | hit1;
    assign hit_way   = hit1;
    assign mem_rdata = hit_way ? line1 : line0;

    // lru bit names the way to evict next
    assign lru_way = lru[index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru <= '0;
        end else if (load_lru) begin
            lru[index] <= hit ? ~hit_way : ~lru_way;
        end
    end

    // victim side for write-back
    assign victim_tag   = lru_way ? tag1 : tag0;
    assign victim_dirty = lru_way ? (valid1 & dirty1) : (valid0 & dirty0);
    assign pmem_wdata   = lru_way ? line1 : line0;

    assign pmem_address = wb_way_sel ? {victim_tag, index, {OFFSET_BITS{1'b0}}}
                                     : {mem_address[ADDR_BITS-1:OFFSET_BITS],
                                        {OFFSET_BITS{1'b0}}};

endmodule : l2_cache_datapath

/* source/l2_cache_control.sv */
`timescale 1ns/1ps

module l2_cache_control import l2_pkg::*; #(
    parameter int INDEX_BITS = 3
) (
    input  logic    clk,
    input  logic    arst_n,

    // cpu side strobes
    input  logic    mem_read,
    input  logic    mem_write,
    output logic    mem_resp,

    // main memory side strobes
    input  logic    pmem_resp,
    output logic    pmem_read,
    output logic    pmem_write,

    // status from the datapath
    input  logic    hit,
    input  logic    hit_way,
    input  logic    lru_way,
    input  logic    victim_dirty,

    // datapath steering
    output logic    load_way0,
    output logic    load_way1,
    output logic    load_lru,
    output logic    cpu_line_sel,
    output logic    dirty_set,
    output logic    wb_way_sel,

    output l2_count hit_count,
    output l2_count miss_count
);

    // at least one tag bit must remain above index and offset
    if (INDEX_BITS < 1 || INDEX_BITS > ADDR_BITS - OFFSET_BITS - 1) begin : g_index_range
        $error("l2_cache_control: INDEX_BITS out of range");
    end

    typedef enum logic [1:0] {
        hit_s,
        write_back_s,
        fetch_s,
        fill_s
    } l2_state;

    l2_state state;
    l2_state next_state;
    logic    request;
    logic    missed;

    assign request = mem_read | mem_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= hit_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        mem_resp     = 1'b0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        load_way0    = 1'b0;
        load_way1    = 1'b0;
        load_lru     = 1'b0;
        cpu_line_sel = 1'b0;
        dirty_set    = 1'b0;
        wb_way_sel   = 1'b0;

        case (state)
            hit_s: begin
                if (request && hit) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    // a write hit replaces the whole line
                    if (mem_write) begin
                        cpu_line_sel = 1'b1;
                        dirty_set    = 1'b1;
                        load_way0    = ~hit_way;
                        load_way1    = hit_way;
                    end
                end else if (request) begin
                    next_state = victim_dirty ? write_back_s : fetch_s;
                end
            end
            write_back_s: begin
                pmem_write = 1'b1;
                wb_way_sel = 1'b1;
                if (pmem_resp) begin
                    next_state = fetch_s;
                end
            end
            fetch_s: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    next_state = fill_s;
                end
            end
            fill_s: begin
                // replace the lru way, cpu data wins on writes
                load_way0    = ~lru_way;
                load_way1    = lru_way;
                load_lru     = 1'b1;
                cpu_line_sel = mem_write;
                dirty_set    = mem_write;
                next_state   = hit_s;
            end
            default: begin
                next_state = hit_s;
            end
        endcase
    end

    // completion of a request that missed counts as one miss only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            missed     <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else if (mem_resp) begin
            missed <= 1'b0;
            if (missed) begin
                miss_count <= miss_count + 1'b1;
            end else begin
                hit_count <= hit_count + 1'b1;
            end
        end else if (state == hit_s && request) begin
            missed <= 1'b1;
        end
    end

endmodule : l2_cache_control

/* source/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache import l2_pkg::*; #(
    parameter int INDEX_BITS = 3
) (
    input  logic    clk,
    input  logic    arst_n,

    // first-level cache side
    input  logic    mem_read,
    input  logic    mem_write,
    input  l2_addr  mem_address,
    input  l2_line  mem_wdata,
    output logic    mem_resp,
    output l2_line  mem_rdata,

    // main memory side
    input  logic    pmem_resp,
    input  l2_line  pmem_rdata,
    output logic    pmem_read,
    output logic    pmem_write,
    output l2_addr  pmem_address,
    output l2_line  pmem_wdata,

    output l2_count hit_count,
    output l2_count miss_count
);

    logic hit;
    logic hit_way;
    logic lru_way;
    logic victim_dirty;
    logic load_way0;
    logic load_way1;
    logic load_lru;
    logic cpu_line_sel;
    logic dirty_set;
    logic wb_way_sel;

    l2_cache_control #(.INDEX_BITS(INDEX_BITS)) control (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_resp    (pmem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .hit          (hit),
        .hit_way      (hit_way),
        .lru_way      (lru_way),
        .victim_dirty (victim_dirty),
        .load_way0    (load_way0),
        .load_way1    (load_way1),
        .load_lru     (load_lru),
        .cpu_line_sel (cpu_line_sel),
        .dirty_set    (dirty_set),
        .wb_way_sel   (wb_way_sel),
        .hit_count    (hit_count),
        .miss_count   (miss_count)
    );

    l2_cache_datapath #(.INDEX_BITS(INDEX_BITS)) datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_address (pmem_address),
        .load_way0    (load_way0),
        .load_way1    (load_way1),
        .load_lru     (load_lru),
        .cpu_line_sel (cpu_line_sel),
        .dirty_set    (dirty_set),
        .wb_way_sel   (wb_way_sel),
        .hit          (hit),
        .hit_way      (hit_way),
        .lru_way      (lru_way),
        .victim_dirty (victim_dirty)
    );

endmodule : l2_cache

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, away from the sampling points
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule : tb_clock

/* tests/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model import l2_pkg::*; #(
    parameter int LATENCY = 4
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   pmem_read,
    input  logic   pmem_write,
    input  l2_addr pmem_address,
    input  l2_line pmem_wdata,
    output logic   pmem_resp,
    output l2_line pmem_rdata
);

    localparam int LINES = 1 << (ADDR_BITS - OFFSET_BITS);

    l2_line lines [LINES];
    int     count;

    // each line holds its own start address in every 16-bit word
    initial begin
        for (int i = 0; i < LINES; i++) begin
            lines[i] = {8{16'(i << OFFSET_BITS)}};
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count      <= 0;
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
        end else begin
            pmem_resp <= 1'b0;
            // no new transfer in the response cycle itself
            if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (count == LATENCY - 1) begin
                    count     <= 0;
                    pmem_resp <= 1'b1;
                    if (pmem_write) begin
                        lines[pmem_address[ADDR_BITS-1:OFFSET_BITS]] <= pmem_wdata;
                    end else begin
                        pmem_rdata <= lines[pmem_address[ADDR_BITS-1:OFFSET_BITS]];
                    end
                end else begin
                    count <= count + 1;
                end
            end
        end
    end

endmodule : l2_mem_model

/* tests/l2_cache_tb.sv */
`timescale 1ns/1ps

module l2_cache_tb import l2_pkg::*;;

    localparam int INDEX_BITS     = 3;
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int SETS           = 1 << INDEX_BITS;
    localparam int N_DIRECT       = 15;
    localparam int N_RANDOM       = 60;
    localparam int N_TOTAL        = N_DIRECT + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 40;

    logic    clk;
    logic    arst_n;
    logic    mem_read;
    logic    mem_write;
    l2_addr  mem_address;
    l2_line  mem_wdata;
    logic    mem_resp;
    l2_line  mem_rdata;
    logic    pmem_resp;
    l2_line  pmem_rdata;
    logic    pmem_read;
    logic    pmem_write;
    l2_addr  pmem_address;
    l2_line  pmem_wdata;
    l2_count hit_count;
    l2_count miss_count;

    // stimulus table
    bit     tbl_write [N_TOTAL];
    l2_addr tbl_addr [N_TOTAL];
    l2_line tbl_data [N_TOTAL];
    int     n_entries = 0;

    // shadow cache and memory
    logic [TAG_BITS-1:0] m_tag [SETS][2];
    bit                  m_valid [SETS][2];
    bit                  m_dirty [SETS][2];
    l2_line              m_data [SETS][2];
    bit                  m_lru [SETS];
    l2_line              shadow [1 << (ADDR_BITS - OFFSET_BITS)];

    logic [31:0] lcg_state = 32'd85;
    int          cycles = 0;
    int          total_xfers = 0;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(3)) clock (.clk(clk), .arst_n(arst_n));

    l2_mem_model #(.LATENCY(4)) mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

    l2_cache #(.INDEX_BITS(INDEX_BITS)) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .hit_count    (hit_count),
        .miss_count   (miss_count)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (pmem_resp) begin
            total_xfers <= total_xfers + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no response within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic l2_addr make_addr(input int tag, input int set);
        return l2_addr'((tag << (INDEX_BITS + OFFSET_BITS)) | (set << OFFSET_BITS));
    endfunction

    task automatic check_value(input string what, input l2_line expected, input l2_line actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input bit is_write, input int tag, input int set, input l2_line data);
        tbl_write[n_entries] = is_write;
        tbl_addr[n_entries]  = make_addr(tag, set);
        tbl_data[n_entries]  = data;
        n_entries++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // cold miss then hit, write hit then read
        add_entry(0, 1, 4, '0);
        add_entry(0, 1, 4, '0);
        add_entry(1, 1, 4, 128'hdead_beef_0123_4567_89ab_cdef_cafe_f00d);
        add_entry(0, 1, 4, '0);
        // clean lru eviction in set 5
        add_entry(0, 1, 5, '0);
        add_entry(0, 2, 5, '0);
        add_entry(0, 1, 5, '0);
        add_entry(0, 3, 5, '0);
        add_entry(0, 1, 5, '0);
        add_entry(0, 2, 5, '0);
        // dirty eviction of tag 1 in set 4, then read it back
        add_entry(0, 2, 4, '0);
        add_entry(0, 3, 4, '0);
        add_entry(0, 1, 4, '0);
        // write miss
        add_entry(1, 5, 6, 128'h1111_2222_3333_4444_5555_6666_7777_8888);
        add_entry(0, 5, 6, '0);
        for (int i = 0; i < N_RANDOM; i++) begin
            r = lcg_next();
            add_entry(r[20], int'(r[23:22]), int'(r[25:24]),
                      {lcg_next(), lcg_next(), lcg_next(), lcg_next()});
        end
    endtask

    task automatic model_access(input bit is_write, input l2_addr addr, input l2_line wdata,
                                output l2_line rdata, output bit was_hit,
                                output int transfers, output int wb_line);
        int                  set;
        int                  way;
        logic [TAG_BITS-1:0] tag;
        set       = int'(addr[OFFSET_BITS +: INDEX_BITS]);
        tag       = addr[ADDR_BITS-1 -: TAG_BITS];
        way       = -1;
        transfers = 0;
        wb_line   = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                way = w;
            end
        end
        was_hit = (way >= 0);
        if (!was_hit) begin
            way       = m_lru[set] ? 1 : 0;
            transfers = 1;
            if (m_valid[set][way] && m_dirty[set][way]) begin
                wb_line         = (int'(m_tag[set][way]) << INDEX_BITS) | set;
                shadow[wb_line] = m_data[set][way];
                transfers       = 2;
            end
            m_data[set][way]  = shadow[addr[ADDR_BITS-1:OFFSET_BITS]];
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end
        if (is_write) begin
            m_data[set][way]  = wdata;
            m_dirty[set][way] = 1'b1;
        end
        // the other way becomes the next victim
        m_lru[set] = (way == 0);
        rdata      = m_data[set][way];
    endtask

    task automatic run_entry(input int idx, output l2_line rdata);
        mem_read    = !tbl_write[idx];
        mem_write   = tbl_write[idx];
        mem_address = tbl_addr[idx];
        mem_wdata   = tbl_data[idx];
        do @(negedge clk); while (!mem_resp);
        rdata = mem_rdata;
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    initial begin
        l2_line exp_rdata;
        l2_line rdata;
        bit     was_hit;
        int     transfers;
        int     wb_line;
        int     start_xfers;
        int     exp_hits;
        int     exp_misses;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        exp_hits    = 0;
        exp_misses  = 0;
        for (int i = 0; i < (1 << (ADDR_BITS - OFFSET_BITS)); i++) begin
            shadow[i] = {8{16'(i << OFFSET_BITS)}};
        end
        build_table();
        wait (arst_n);
        @(posedge clk);
        #1;
        for (int i = 0; i < n_entries; i++) begin
            model_access(tbl_write[i], tbl_addr[i], tbl_data[i], exp_rdata, was_hit,
                         transfers, wb_line);
            start_xfers = total_xfers;
            run_entry(i, rdata);
            if (was_hit) begin
                exp_hits++;
            end else begin
                exp_misses++;
            end
            if (!tbl_write[i]) begin
                check_value($sformatf("entry %0d read data", i), exp_rdata, rdata);
            end
            check_value($sformatf("entry %0d hit_count", i), 128'(exp_hits), 128'(hit_count));
            check_value($sformatf("entry %0d miss_count", i), 128'(exp_misses),
                        128'(miss_count));
            check_value($sformatf("entry %0d memory transfers", i), 128'(transfers),
                        128'(total_xfers - start_xfers));
            if (wb_line >= 0) begin
                check_value($sformatf("entry %0d written back line", i), shadow[wb_line],
                            mem.lines[wb_line]);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule : l2_cache_tb

/* l2_cache.f */
source/l2_pkg.sv
source/l2_cache_way.sv
source/l2_cache_datapath.sv
source/l2_cache_control.sv
source/l2_cache.sv
tests/tb_clock.sv
tests/l2_mem_model.sv
tests/l2_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= l2_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard source/*.sv tests/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
